/* sources.f */
+incdir+design
design/ooo_pkg.sv
design/rob.sv
design/rename_table.sv
design/store_queue.sv
design/ooo_backend.sv
verification/ooo_backend_tb.sv

/* run.sh */
#!/bin/sh
# builds and runs the ooo_backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module ooo_backend_tb \
    -f sources.f --Mdir obj_dir -o ooo_backend_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/ooo_backend_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1

/* verification/backend_cases.txt */
# action name args; alloc: rd is_store pred exp_tag(-1 none); wb: tag data(h) taken target(h)
# store: tag addr data; lookup: rs busy tag; full: level; idle: cycles; commit: rd data
commit   inorder 1 00000011
commit   inorder 2 00000022
commit   inorder 3 00000033
alloc    reset_tag0 1 0 0 0
alloc    inorder 2 0 0 1
alloc    inorder 3 0 0 2
wb       inorder 2 00000033 0 0
wb       inorder 1 00000022 0 0
wb       inorder 0 00000011 0 0
idle     inorder 4
commit   rename 7 00000077
commit   rename 7 00000078
alloc    rename 7 0 0 3
alloc    rename 7 0 0 4
lookup   rename_second 7 1 4
lookup   rename_x0 0 0 0
wb       rename 3 00000077 0 0
idle     rename 3
lookup   rename_survive 7 1 4
wb       rename 4 00000078 0 0
idle     rename 3
lookup   rename_clear 7 0 0
commit   store 4 00000044
memwrite store 00001000 0000abcd
commit   store 5 00000055
alloc    store 4 0 0 5
alloc    store 0 1 0 6
alloc    store 5 0 0 7
wb       store 7 00000055 0 0
store    store 6 00001000 0000abcd
wb       store 5 00000044 0 0
idle     store 8
commit   mispredict 8 00000080
redirect mispredict 00002000
alloc    mispredict 8 0 0 8
alloc    mispredict 9 0 0 9
alloc    mispredict 10 0 0 10
wb       mispredict 10 000000a0 0 0
wb       mispredict 9 00000090 0 0
wb       mispredict 8 00000080 1 00002000
idle     mispredict 4
lookup   mispredict_flush 9 0 0
commit   capacity 12 000000c0
alloc    capacity_tag0 12 0 0 0
alloc    capacity 12 0 0 1
alloc    capacity 12 0 0 2
alloc    capacity 12 0 0 3
alloc    capacity 12 0 0 4
alloc    capacity 12 0 0 5
alloc    capacity 12 0 0 6
alloc    capacity 12 0 0 7
alloc    capacity 12 0 0 8
alloc    capacity 12 0 0 9
alloc    capacity 12 0 0 10
alloc    capacity 12 0 0 11
alloc    capacity 12 0 0 12
alloc    capacity 12 0 0 13
alloc    capacity 12 0 0 14
alloc    capacity 12 0 0 15
full     capacity_full 1
alloc    capacity_drop 12 0 0 -1
wb       capacity 0 000000c0 0 0
idle     capacity 2
full     capacity_free 0
alloc    capacity_wrap 13 0 0 0
idle     capacity 2

/* verification/ooo_backend_tb.sv */
`include "ooo_params.svh"

module ooo_backend_tb;
    import ooo_pkg::*;

    localparam string CASES_FILE   = "verification/backend_cases.txt";
    localparam int    RESET_CYCLES = 10;
    localparam int    DRAIN_CYCLES = 20;

    logic                   clk;
    logic                   rst;
    logic                   alloc_en;
    alloc_req_t             alloc;
    logic                   wb_en;
    exec_wb_t               wb;
    logic                   st_en;
    store_exec_t            st;
    reg_name_t              lookup_rs;
    rob_tag_t               alloc_tag;
    logic                   rob_full;
    logic                   lookup_busy;
    rob_tag_t               lookup_tag;
    logic                   commit_en;
    commit_t                commit;
    logic                   mem_wr_en;
    mem_write_t             mem_wr;
    logic                   redirect;
    logic [`OOO_ADDR_W-1:0] redirect_pc;

    string       lines[$];
    string       commit_name_q[$];
    reg_name_t   commit_rd_q[$];
    logic [31:0] commit_data_q[$];
    string       mem_name_q[$];
    logic [31:0] mem_addr_q[$];
    logic [31:0] mem_data_q[$];
    string       redir_name_q[$];
    logic [31:0] redir_pc_q[$];
    rob_tag_t    retire_ptr = '0;  // tag expected at the next retirement
    int          cycles = 0;
    int          limit  = 1000000;

    ooo_backend i_ooo_backend (
        .clk, .rst, .alloc_en, .alloc, .wb_en, .wb, .st_en, .st, .lookup_rs,
        .alloc_tag, .rob_full, .lookup_busy, .lookup_tag,
        .commit_en, .commit, .mem_wr_en, .mem_wr, .redirect, .redirect_pc
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic string mismatch(input string nm, input logic [31:0] exp,
                                       input logic [31:0] act);
        return $sformatf("Mismatch %s: expected %h, actual %h", nm, exp, act);
    endfunction

    task automatic clear_inputs();
        alloc_en = 1'b0;
        wb_en    = 1'b0;
        st_en    = 1'b0;
    endtask

    // watchdog
    always @(posedge clk) begin
        cycles++;
        assert (cycles <= limit) else
            stop_on_error($sformatf("timeout after %0d cycles", cycles));
    end

    // scoreboard, registered outputs sampled before the edge updates them
    always @(posedge clk) begin
        if (!rst && commit_en) begin
            assert (commit_rd_q.size() > 0) else
                stop_on_error($sformatf("commit of tag %0d that no case expects", commit.tag));
            assert (commit.tag == retire_ptr) else
                stop_on_error(mismatch(commit_name_q[0], 32'(retire_ptr), 32'(commit.tag)));
            assert (commit.rd == commit_rd_q[0]) else
                stop_on_error(mismatch(commit_name_q[0], 32'(commit_rd_q[0]), 32'(commit.rd)));
            assert (commit.data == commit_data_q[0]) else
                stop_on_error(mismatch(commit_name_q[0], commit_data_q[0], commit.data));
            void'(commit_name_q.pop_front());
            void'(commit_rd_q.pop_front());
            void'(commit_data_q.pop_front());
            retire_ptr = retire_ptr + 1'b1;  // head walks in program order
        end
        if (!rst && redirect) begin
            assert (commit_en) else
                stop_on_error("redirect raised without a commit in the same cycle");
            assert (redir_pc_q.size() > 0) else
                stop_on_error("redirect that no case expects");
            assert (redirect_pc == redir_pc_q[0]) else
                stop_on_error(mismatch(redir_name_q[0], redir_pc_q[0], redirect_pc));
            void'(redir_name_q.pop_front());
            void'(redir_pc_q.pop_front());
            retire_ptr = '0;  // flush restarts the rob at tag 0
        end
        if (!rst && mem_wr_en) begin
            assert (mem_addr_q.size() > 0) else
                stop_on_error("memory write that no case expects");
            assert (mem_wr.addr == mem_addr_q[0]) else
                stop_on_error(mismatch(mem_name_q[0], mem_addr_q[0], mem_wr.addr));
            assert (mem_wr.data == mem_data_q[0]) else
                stop_on_error(mismatch(mem_name_q[0], mem_data_q[0], mem_wr.data));
            void'(mem_name_q.pop_front());
            void'(mem_addr_q.pop_front());
            void'(mem_data_q.pop_front());
            retire_ptr = retire_ptr + 1'b1;
        end
        if (!rst && lookup_rs == '0) begin
            assert (!lookup_busy) else
                stop_on_error("register x0 shown busy in the rename table");
        end
    end

    function automatic int line_cycles(input string line);
        string kw;
        string nm;
        int    n;
        void'($sscanf(line, "%s", kw));
        if (kw == "idle") begin
            void'($sscanf(line, "%s %s %d", kw, nm, n));
            return n;
        end
        if (kw == "commit" || kw == "memwrite" || kw == "redirect") begin
            return 0;
        end
        return 1;
    endfunction

    task automatic run_line(input string line);
        string       kw;
        string       nm;
        int          a;
        int          b;
        int          c;
        int          d;
        logic [31:0] x;
        logic [31:0] y;
        void'($sscanf(line, "%s %s", kw, nm));
        case (kw)
            "commit": begin
                void'($sscanf(line, "%s %s %d %h", kw, nm, a, x));
                commit_name_q.push_back(nm);
                commit_rd_q.push_back(reg_name_t'(a));
                commit_data_q.push_back(x);
            end
            "memwrite": begin
                void'($sscanf(line, "%s %s %h %h", kw, nm, x, y));
                mem_name_q.push_back(nm);
                mem_addr_q.push_back(x);
                mem_data_q.push_back(y);
            end
            "redirect": begin
                void'($sscanf(line, "%s %s %h", kw, nm, x));
                redir_name_q.push_back(nm);
                redir_pc_q.push_back(x);
            end
            "alloc": begin
                void'($sscanf(line, "%s %s %d %d %d %d", kw, nm, a, b, c, d));
                @(negedge clk);
                clear_inputs();
                alloc_en = 1'b1;
                alloc    = '{rd: reg_name_t'(a), is_store: b[0], pred_taken: c[0]};
                if (a == 0) begin
                    lookup_rs = '0;  // x0 as destination stays under watch
                end
                #1;
                if (d >= 0) begin
                    assert (alloc_tag == rob_tag_t'(d)) else
                        stop_on_error(mismatch(nm, 32'(d), 32'(alloc_tag)));
                end
            end
            "wb": begin
                void'($sscanf(line, "%s %s %d %h %d %h", kw, nm, a, x, b, y));
                @(negedge clk);
                clear_inputs();
                wb_en = 1'b1;
                wb    = '{tag: rob_tag_t'(a), data: x, taken: b[0], target: y};
            end
            "store": begin
                void'($sscanf(line, "%s %s %d %h %h", kw, nm, a, x, y));
                @(negedge clk);
                clear_inputs();
                st_en = 1'b1;
                st    = '{tag: rob_tag_t'(a), addr: x, data: y};
            end
            "lookup": begin
                void'($sscanf(line, "%s %s %d %d %d", kw, nm, a, b, c));
                @(negedge clk);
                clear_inputs();
                lookup_rs = reg_name_t'(a);
                #1;
                assert (lookup_busy == b[0]) else
                    stop_on_error(mismatch(nm, 32'(b[0]), 32'(lookup_busy)));
                if (b != 0) begin
                    assert (lookup_tag == rob_tag_t'(c)) else
                        stop_on_error(mismatch(nm, 32'(c), 32'(lookup_tag)));
                end
            end
            "full": begin
                void'($sscanf(line, "%s %s %d", kw, nm, a));
                @(negedge clk);
                clear_inputs();
                #1;
                assert (rob_full == a[0]) else
                    stop_on_error(mismatch(nm, 32'(a[0]), 32'(rob_full)));
            end
            "idle": begin
                void'($sscanf(line, "%s %s %d", kw, nm, a));
                repeat (a) begin
                    @(negedge clk);
                    clear_inputs();
                end
            end
            default: stop_on_error($sformatf("unknown action in cases file: %s", line));
        endcase
    endtask

    initial begin
        int    fd;
        int    total;
        string line;
        string kw;
        rst       = 1'b1;
        alloc_en  = 1'b0;
        alloc     = '0;
        wb_en     = 1'b0;
        wb        = '0;
        st_en     = 1'b0;
        st        = '0;
        lookup_rs = '0;
        total     = RESET_CYCLES + DRAIN_CYCLES + 2;
        fd = $fopen(CASES_FILE, "r");
        assert (fd != 0) else stop_on_error("cannot open the cases file");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            kw = "";
            void'($sscanf(line, "%s", kw));
            if (kw != "" && kw.substr(0, 0) != "#") begin
                lines.push_back(line);
                total += line_cycles(line);
            end
        end
        $fclose(fd);
        limit = 4 * total + 100;

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        #1;
        assert (!commit_en && !mem_wr_en && !redirect && !rob_full && !lookup_busy) else
            stop_on_error("outputs not low right after reset");

        foreach (lines[i]) begin
            run_line(lines[i]);
        end
        @(negedge clk);
        clear_inputs();
        repeat (DRAIN_CYCLES) @(negedge clk);

        assert (commit_rd_q.size() == 0) else
            stop_on_error($sformatf("%0d expected commits never appeared", commit_rd_q.size()));
        assert (mem_addr_q.size() == 0) else
            stop_on_error("an expected memory write never appeared");
        assert (redir_pc_q.size() == 0) else
            stop_on_error("an expected redirect never appeared");

        $display("No errors");
        $finish;
    end

endmodule

/* design/ooo_backend.sv */
`include "ooo_params.svh"

module ooo_backend (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   alloc_en,
    input  ooo_pkg::alloc_req_t    alloc,
    input  logic                   wb_en,
    input  ooo_pkg::exec_wb_t      wb,
    input  logic                   st_en,
    input  ooo_pkg::store_exec_t   st,
    input  ooo_pkg::reg_name_t     lookup_rs,
    output ooo_pkg::rob_tag_t      alloc_tag,
    output logic                   rob_full,
    output logic                   lookup_busy,
    output ooo_pkg::rob_tag_t      lookup_tag,
    output logic                   commit_en,
    output ooo_pkg::commit_t       commit,
    output logic                   mem_wr_en,
    output ooo_pkg::mem_write_t    mem_wr,
    output logic                   redirect,
    output logic [`OOO_ADDR_W-1:0] redirect_pc
);
    import ooo_pkg::*;

    logic      alloc_grant;
    logic      retire_en;
    rob_tag_t  retire_tag;
    reg_name_t retire_rd;
    logic      store_release;
    rob_tag_t  release_tag;
    logic      store_done;
    logic      flush;

    rob i_rob (
        .clk, .rst,
        .alloc_en, .alloc, .wb_en, .wb,
        .st_en, .st_tag(st.tag),  // same strobe completes the store entry
        .store_done,
        .alloc_tag, .rob_full, .alloc_grant,
        .retire_en, .retire_tag, .retire_rd,
        .commit_en, .commit,
        .store_release, .release_tag,
        .redirect, .redirect_pc, .flush
    );

    rename_table i_rename_table (
        .clk, .rst, .flush,
        .alloc_grant, .alloc_tag, .alloc_rd(alloc.rd),
        .retire_en, .retire_tag, .retire_rd,
        .lookup_rs, .lookup_busy, .lookup_tag
    );

    store_queue i_store_queue (
        .clk, .rst, .flush,
        .st_en, .st,
        .store_release, .release_tag,
        .mem_wr_en, .mem_wr, .store_done
    );

endmodule

/* design/store_queue.sv */
`include "ooo_params.svh"

module store_queue (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                st_en,
    input  ooo_pkg::store_exec_t st,
    input  logic                store_release,
    input  ooo_pkg::rob_tag_t   release_tag,
    output logic                mem_wr_en,
    output ooo_pkg::mem_write_t mem_wr,
    output logic                store_done
);
    import ooo_pkg::*;

    // one slot per rob tag
    logic [`OOO_ROB_DEPTH-1:0] valid_q;
    logic [`OOO_ADDR_W-1:0]    addr_q [`OOO_ROB_DEPTH];
    logic [`OOO_DATA_W-1:0]    data_q [`OOO_ROB_DEPTH];

    mem_write_t slot_rd;

    assign slot_rd = '{addr: addr_q[release_tag], data: data_q[release_tag]};

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_q <= '0;
        end else begin
            if (st_en) begin
                valid_q[st.tag] <= 1'b1;
            end
            if (store_release) begin
                valid_q[release_tag] <= 1'b0;  // slot already read out
            end
        end
    end

    always_ff @(posedge clk) begin
        if (st_en) begin
            addr_q[st.tag] <= st.addr;
            data_q[st.tag] <= st.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wr_en <= 1'b0;
        end else begin
            mem_wr_en <= store_release;
        end
    end

    always_ff @(posedge clk) begin
        if (store_release) begin
            mem_wr <= slot_rd;
        end
    end

    // rob frees the head store on this
    assign store_done = mem_wr_en;

    a_release_valid: assert property (@(posedge clk) disable iff (rst)
        store_release |-> valid_q[release_tag]);

endmodule

/* design/rename_table.sv */
`include "ooo_params.svh"

module rename_table (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               alloc_grant,
    input  ooo_pkg::rob_tag_t  alloc_tag,
    input  ooo_pkg::reg_name_t alloc_rd,
    input  logic               retire_en,
    input  ooo_pkg::rob_tag_t  retire_tag,
    input  ooo_pkg::reg_name_t retire_rd,
    input  ooo_pkg::reg_name_t lookup_rs,
    output logic               lookup_busy,
    output ooo_pkg::rob_tag_t  lookup_tag
);
    import ooo_pkg::*;

    logic [(2 ** `OOO_REG_W)-1:0] busy_q;
    rob_tag_t                     tag_q [2 ** `OOO_REG_W];

    logic alloc_set;
    logic retire_clr;

    assign alloc_set = alloc_grant && (alloc_rd != '0);  // x0 stays free

    // a younger producer keeps the register busy
    assign retire_clr = retire_en && busy_q[retire_rd] && (tag_q[retire_rd] == retire_tag);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy_q <= '0;
        end else begin
            if (retire_clr) begin
                busy_q[retire_rd] <= 1'b0;
            end
            // allocation wins on the same register
            if (alloc_set) begin
                busy_q[alloc_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_set) begin
            tag_q[alloc_rd] <= alloc_tag;
        end
    end

    assign lookup_busy = busy_q[lookup_rs];
    assign lookup_tag  = tag_q[lookup_rs];

    a_alloc_wins: assert property (@(posedge clk) disable iff (rst || flush)
        alloc_set && retire_en && (retire_rd == alloc_rd)
        |=> busy_q[$past(alloc_rd)] && (tag_q[$past(alloc_rd)] == $past(alloc_tag)));

endmodule

/* design/rob.sv */
`include "ooo_params.svh"

module rob (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   alloc_en,
    input  ooo_pkg::alloc_req_t    alloc,
    input  logic                   wb_en,
    input  ooo_pkg::exec_wb_t      wb,
    input  logic                   st_en,
    input  ooo_pkg::rob_tag_t      st_tag,
    input  logic                   store_done,
    output ooo_pkg::rob_tag_t      alloc_tag,
    output logic                   rob_full,
    output logic                   alloc_grant,
    output logic                   retire_en,
    output ooo_pkg::rob_tag_t      retire_tag,
    output ooo_pkg::reg_name_t     retire_rd,
    output logic                   commit_en,
    output ooo_pkg::commit_t       commit,
    output logic                   store_release,
    output ooo_pkg::rob_tag_t      release_tag,
    output logic                   redirect,
    output logic [`OOO_ADDR_W-1:0] redirect_pc,
    output logic                   flush
);
    import ooo_pkg::*;

    // per entry state
    logic [`OOO_ROB_DEPTH-1:0] occ_q;
    logic [`OOO_ROB_DEPTH-1:0] done_q;
    logic [`OOO_ROB_DEPTH-1:0] store_q;
    logic [`OOO_ROB_DEPTH-1:0] pred_q;
    logic [`OOO_ROB_DEPTH-1:0] taken_q;
    reg_name_t                 rd_q     [`OOO_ROB_DEPTH];
    logic [`OOO_DATA_W-1:0]    data_q   [`OOO_ROB_DEPTH];
    logic [`OOO_ADDR_W-1:0]    target_q [`OOO_ROB_DEPTH];

    rob_tag_t            rd_ptr;
    rob_tag_t            wr_ptr;
    logic [`OOO_TAG_W:0] count_q;
    logic [`OOO_TAG_W:0] count_next;
    logic                st_pending;  // store released, waiting for store_done

    logic head_ready;
    logic reg_retire;
    logic st_start;
    logic free_head;
    logic wb_ok;
    logic st_ok;

    function automatic rob_tag_t ptr_inc(input rob_tag_t p);
        if (p == rob_tag_t'(`OOO_ROB_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // nothing is accepted while the redirect is up
    assign alloc_grant = alloc_en && !rob_full && !redirect;
    assign alloc_tag   = wr_ptr;
    assign wb_ok       = wb_en && !redirect;
    assign st_ok       = st_en && !redirect;

    assign head_ready = occ_q[rd_ptr] && done_q[rd_ptr];
    assign reg_retire = head_ready && !store_q[rd_ptr] && !redirect;
    assign st_start   = head_ready && store_q[rd_ptr] && !st_pending && !redirect;
    assign free_head  = reg_retire || store_done;  // store frees on done

    assign retire_en  = free_head;
    assign retire_tag = rd_ptr;
    assign retire_rd  = rd_q[rd_ptr];

    assign flush = redirect;

    always_comb begin
        count_next = count_q;
        if (alloc_grant && !free_head) begin
            count_next = count_q + 1'b1;
        end else if (!alloc_grant && free_head) begin
            count_next = count_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            occ_q      <= '0;
            done_q     <= '0;
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            count_q    <= '0;
            rob_full   <= 1'b0;
            st_pending <= 1'b0;
        end else begin
            if (alloc_grant) begin
                occ_q[wr_ptr]  <= 1'b1;
                done_q[wr_ptr] <= 1'b0;
                wr_ptr         <= ptr_inc(wr_ptr);
            end
            if (wb_ok) begin
                done_q[wb.tag] <= 1'b1;
            end
            if (st_ok) begin
                done_q[st_tag] <= 1'b1;
            end
            if (free_head) begin
                occ_q[rd_ptr]  <= 1'b0;
                done_q[rd_ptr] <= 1'b0;
                rd_ptr         <= ptr_inc(rd_ptr);
            end
            if (st_start) begin
                st_pending <= 1'b1;
            end else if (store_done) begin
                st_pending <= 1'b0;
            end
            count_q  <= count_next;
            rob_full <= (count_next == (`OOO_TAG_W + 1)'(`OOO_ROB_DEPTH));
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_grant) begin
            rd_q[wr_ptr]    <= alloc.rd;
            store_q[wr_ptr] <= alloc.is_store;
            pred_q[wr_ptr]  <= alloc.pred_taken;
        end
        if (wb_ok) begin
            data_q[wb.tag]   <= wb.data;
            taken_q[wb.tag]  <= wb.taken;
            target_q[wb.tag] <= wb.target;
        end
    end

    // retirement strobes, one cycle each
    always_ff @(posedge clk) begin
        if (rst) begin
            commit_en     <= 1'b0;
            redirect      <= 1'b0;
            store_release <= 1'b0;
        end else begin
            commit_en     <= reg_retire;
            redirect      <= reg_retire && (pred_q[rd_ptr] != taken_q[rd_ptr]);
            store_release <= st_start;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_retire) begin
            commit      <= '{tag: rd_ptr, rd: rd_q[rd_ptr], data: data_q[rd_ptr]};
            redirect_pc <= target_q[rd_ptr];
        end
        if (st_start) begin
            release_tag <= rd_ptr;
        end
    end

    // results only land on live entries
    a_wb_live: assert property (@(posedge clk) disable iff (rst)
        (wb_ok |-> occ_q[wb.tag]) and (st_ok |-> occ_q[st_tag]));

    a_done_pending: assert property (@(posedge clk) disable iff (rst)
        store_done |-> st_pending);

    // count based full flag must agree with the slot bits
    a_grant_free: assert property (@(posedge clk) disable iff (rst)
        alloc_grant |-> !occ_q[wr_ptr]);

endmodule

/* design/ooo_pkg.sv */
`include "ooo_params.svh"

package ooo_pkg;

    typedef logic [`OOO_TAG_W-1:0] rob_tag_t;
    typedef logic [`OOO_REG_W-1:0] reg_name_t;

    // front end request, one per granted alloc
    typedef struct packed {
        reg_name_t rd;
        logic      is_store;
        logic      pred_taken;
    } alloc_req_t;

    // result from an execution unit
    typedef struct packed {
        rob_tag_t               tag;
        logic [`OOO_DATA_W-1:0] data;
        logic                   taken;  // actual branch direction
        logic [`OOO_ADDR_W-1:0] target;
    } exec_wb_t;

    typedef struct packed {
        rob_tag_t               tag;
        logic [`OOO_ADDR_W-1:0] addr;
        logic [`OOO_DATA_W-1:0] data;
    } store_exec_t;

    // retired register write toward the register file
    typedef struct packed {
        rob_tag_t               tag;
        reg_name_t              rd;
        logic [`OOO_DATA_W-1:0] data;
    } commit_t;

    typedef struct packed {
        logic [`OOO_ADDR_W-1:0] addr;
        logic [`OOO_DATA_W-1:0] data;
    } mem_write_t;

endpackage

/* design/ooo_params.svh */
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// reorder buffer size, one word per entry
`define OOO_ROB_DEPTH 16

// tag indexes the rob, so log2 of the depth
`define OOO_TAG_W 4

// x0..x31
`define OOO_REG_W 5

`define OOO_DATA_W 32

// shared by memory addresses and the redirect pc
`define OOO_ADDR_W 32

`endif
